/* include/fw_cfg.svh */
// Firewall build configuration
// Bus widths, timer FIFO depth and counter width

`ifndef FW_CFG_SVH
`define FW_CFG_SVH

// ==============================
// AXI-Lite bus widths
// ==============================
`define FW_ADDR_WIDTH 32
`define FW_DATA_WIDTH 32
`define FW_STRB_WIDTH (`FW_DATA_WIDTH / 8)

// ==============================
// Tracking resources
// ==============================
// Timer slots per channel, power of two so the pointers wrap on their own
`define FW_FIFO_DEPTH 16

// Timer values, outstanding limit and event counters
`define FW_CNT_WIDTH 32

`endif

/* logic/fw_pkg.sv */
// Firewall shared types
// AXI response code, bus words, counter word and response payloads

`include "fw_cfg.svh"

package fw_pkg;

    // AXI response code
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Bus words
    typedef logic [`FW_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`FW_DATA_WIDTH-1:0] data_t;
    typedef logic [`FW_STRB_WIDTH-1:0] strb_t;

    // Timers, limits and event counters
    typedef logic [`FW_CNT_WIDTH-1:0] cnt_t;

    // Outstanding and phantom counts, holds 0 up to the full FIFO depth
    typedef logic [$clog2(`FW_FIFO_DEPTH+1)-1:0] slot_t;

    // Write response payload
    typedef struct packed {
        axi_resp_e resp;
    } b_payload_t;

    // Read response payload
    typedef struct packed {
        data_t     data;
        axi_resp_e resp;
    } r_payload_t;

endpackage

/* logic/fw_request_gate.sv */
// Request gate of the firewall
// Lockdown and room gating of AW, W and AR valid/ready
// Write address/data join with pending flags
// Issue strobes for the response guards

module fw_request_gate (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic lockdown_i,
    input  logic wr_room_i,
    input  logic rd_room_i,
    input  logic s_awvalid_i,
    input  logic s_wvalid_i,
    input  logic s_arvalid_i,
    input  logic m_awready_i,
    input  logic m_wready_i,
    input  logic m_arready_i,
    output logic s_awready_o,
    output logic s_wready_o,
    output logic s_arready_o,
    output logic m_awvalid_o,
    output logic m_wvalid_o,
    output logic m_arvalid_o,
    output logic wr_issue_o,
    output logic rd_issue_o
);

    // Phase already accepted, waiting for its partner
    logic aw_pend_q;
    logic w_pend_q;

    logic wr_open;
    logic rd_open;
    logic aw_acc;
    logic w_acc;

    // ==============================
    // Channel gating
    // ==============================
    // Closed while locked down or while the guard has no room
    assign wr_open = !lockdown_i && wr_room_i;
    assign rd_open = !lockdown_i && rd_room_i;

    // Each write phase passes once per transaction
    assign m_awvalid_o = s_awvalid_i && wr_open && !aw_pend_q;
    assign s_awready_o = m_awready_i && wr_open && !aw_pend_q;
    assign m_wvalid_o  = s_wvalid_i && wr_open && !w_pend_q;
    assign s_wready_o  = m_wready_i && wr_open && !w_pend_q;

    assign m_arvalid_o = s_arvalid_i && rd_open;
    assign s_arready_o = m_arready_i && rd_open;

    // ==============================
    // Issue detection
    // ==============================
    assign aw_acc = s_awvalid_i && s_awready_o;
    assign w_acc  = s_wvalid_i && s_wready_o;

    // Second phase accepted now, or both together
    assign wr_issue_o = (aw_acc || aw_pend_q) && (w_acc || w_pend_q)
                      && (aw_acc || w_acc);
    assign rd_issue_o = s_arvalid_i && s_arready_o;

    // Remember an early phase until the write completes its join
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else if (wr_issue_o) begin
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else begin
            if (aw_acc) begin
                aw_pend_q <= 1'b1;
            end
            if (w_acc) begin
                w_pend_q <= 1'b1;
            end
        end
    end

endmodule

/* logic/fw_response_guard.sv */
// Response guard for one AXI-Lite response channel
// Outstanding and phantom tracking, per-request timer FIFO
// Synthetic response on timeout, unsolicited response filtering
// Merge of synthetic and forwarded responses upstream

`include "fw_cfg.svh"

module fw_response_guard #(
    parameter type payload_t = fw_pkg::b_payload_t
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         issue_i,
    input  fw_pkg::cnt_t timeout_cycles_i,
    input  fw_pkg::cnt_t max_outstanding_i,
    input  payload_t     synth_payload_i,
    input  logic         dn_valid_i,
    input  payload_t     dn_payload_i,
    output logic         dn_ready_o,
    output logic         up_valid_o,
    output payload_t     up_payload_o,
    input  logic         up_ready_i,
    output logic         room_o,
    output logic         timeout_o,
    output logic         unsolicited_o
);

    import fw_pkg::*;

    localparam int unsigned IDX_W = $clog2(`FW_FIFO_DEPTH);

    // Timer FIFO, one countdown per outstanding request in issue order
    cnt_t             timer_q [`FW_FIFO_DEPTH];
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    slot_t            fill_q;

    // Requests not yet answered upstream, and timed-out ones still owed a
    // late response from downstream
    slot_t outstanding_q;
    slot_t phantom_q;

    // Registered synthetic response
    logic     synth_valid_q;
    payload_t synth_payload_q;

    logic fifo_empty;
    logic fifo_full;
    logic unsol_cond;
    logic fwd;
    logic fwd_hs;
    logic synth_hs;
    logic swallow;
    logic expire;
    logic pop;

    assign fifo_empty = (fill_q == '0);
    assign fifo_full  = (fill_q == slot_t'(`FW_FIFO_DEPTH));

    // ==============================
    // Downstream response routing
    // ==============================
    // Anything arriving with a phantom owed or nothing outstanding is dropped
    assign unsol_cond = (phantom_q != '0) || (outstanding_q == '0);
    assign swallow    = dn_valid_i && unsol_cond;

    // Forward only when no synthetic response holds the upstream channel
    assign fwd      = dn_valid_i && !unsol_cond && !synth_valid_q;
    assign fwd_hs   = fwd && up_ready_i;
    assign synth_hs = synth_valid_q && up_ready_i;

    assign dn_ready_o   = unsol_cond || (!synth_valid_q && up_ready_i);
    assign up_valid_o   = synth_valid_q || fwd;
    assign up_payload_o = synth_valid_q ? synth_payload_q : dn_payload_i;

    // ==============================
    // Timeout detection
    // ==============================
    // Head is frozen while a synthetic response waits; a response forwarded
    // in the same cycle completes the head instead of timing it out
    assign expire = !fifo_empty && !synth_valid_q && !fwd_hs
                  && (timer_q[head_q] == '0);
    assign pop    = expire || fwd_hs;

    assign timeout_o     = expire;
    assign unsolicited_o = swallow;

    assign room_o = (cnt_t'(outstanding_q) < max_outstanding_i) && !fifo_full;

    // Timer storage: push at the tail, count the head down
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            timer_q[tail_q] <= timeout_cycles_i;
        end
        if (!fifo_empty && !synth_valid_q && !pop) begin
            timer_q[head_q] <= timer_q[head_q] - cnt_t'(1);
        end
    end

    // FIFO pointers and fill level
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q <= '0;
            tail_q <= '0;
            fill_q <= '0;
        end else begin
            if (issue_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            fill_q <= fill_q + slot_t'(issue_i) - slot_t'(pop);
        end
    end

    // ==============================
    // Counts and synthetic response
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
            phantom_q     <= '0;
            synth_valid_q <= 1'b0;
        end else begin
            // Falls on each upstream response, forwarded or synthetic
            outstanding_q <= outstanding_q + slot_t'(issue_i)
                           - slot_t'(fwd_hs || synth_hs);
            phantom_q     <= phantom_q + slot_t'(expire)
                           - slot_t'(swallow && (phantom_q != '0));
            if (expire) begin
                synth_valid_q <= 1'b1;
            end else if (synth_hs) begin
                synth_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (expire) begin
            synth_payload_q <= synth_payload_i;
        end
    end

endmodule

/* logic/fw_event_counter.sv */
// Firewall event counter
// One-cycle timeout and unsolicited pulses
// Clearable totals over both channels

module fw_event_counter (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         wr_timeout_i,
    input  logic         rd_timeout_i,
    input  logic         wr_unsolicited_i,
    input  logic         rd_unsolicited_i,
    input  logic         clear_counts_i,
    output fw_pkg::cnt_t timeout_count_o,
    output fw_pkg::cnt_t unsolicited_count_o,
    output logic         evt_timeout_o,
    output logic         evt_unsolicited_o
);

    import fw_pkg::*;

    // Both channels may strobe in the same cycle
    logic [1:0] n_timeout;
    logic [1:0] n_unsol;

    assign n_timeout = {1'b0, wr_timeout_i} + {1'b0, rd_timeout_i};
    assign n_unsol   = {1'b0, wr_unsolicited_i} + {1'b0, rd_unsolicited_i};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timeout_count_o     <= '0;
            unsolicited_count_o <= '0;
            evt_timeout_o       <= 1'b0;
            evt_unsolicited_o   <= 1'b0;
        end else begin
            evt_timeout_o     <= wr_timeout_i || rd_timeout_i;
            evt_unsolicited_o <= wr_unsolicited_i || rd_unsolicited_i;
            // Clear wins over a same-cycle increment
            if (clear_counts_i) begin
                timeout_count_o     <= '0;
                unsolicited_count_o <= '0;
            end else begin
                timeout_count_o     <= timeout_count_o + cnt_t'(n_timeout);
                unsolicited_count_o <= unsolicited_count_o + cnt_t'(n_unsol);
            end
        end
    end

endmodule

/* logic/axil_firewall.sv */
// AXI-Lite firewall top level
// Request gate on AW, W and AR
// Response guards on B and R
// Event counter for timeouts and unsolicited responses

module axil_firewall (
    input  logic              clk_i,
    input  logic              rst_ni,

    // ==============================
    // Upstream AXI-Lite slave
    // ==============================
    input  fw_pkg::addr_t     s_axi_awaddr_i,
    input  logic              s_axi_awvalid_i,
    output logic              s_axi_awready_o,
    input  fw_pkg::data_t     s_axi_wdata_i,
    input  fw_pkg::strb_t     s_axi_wstrb_i,
    input  logic              s_axi_wvalid_i,
    output logic              s_axi_wready_o,
    output fw_pkg::axi_resp_e s_axi_bresp_o,
    output logic              s_axi_bvalid_o,
    input  logic              s_axi_bready_i,
    input  fw_pkg::addr_t     s_axi_araddr_i,
    input  logic              s_axi_arvalid_i,
    output logic              s_axi_arready_o,
    output fw_pkg::data_t     s_axi_rdata_o,
    output fw_pkg::axi_resp_e s_axi_rresp_o,
    output logic              s_axi_rvalid_o,
    input  logic              s_axi_rready_i,

    // ==============================
    // Downstream AXI-Lite master
    // ==============================
    output fw_pkg::addr_t     m_axi_awaddr_o,
    output logic              m_axi_awvalid_o,
    input  logic              m_axi_awready_i,
    output fw_pkg::data_t     m_axi_wdata_o,
    output fw_pkg::strb_t     m_axi_wstrb_o,
    output logic              m_axi_wvalid_o,
    input  logic              m_axi_wready_i,
    input  fw_pkg::axi_resp_e m_axi_bresp_i,
    input  logic              m_axi_bvalid_i,
    output logic              m_axi_bready_o,
    output fw_pkg::addr_t     m_axi_araddr_o,
    output logic              m_axi_arvalid_o,
    input  logic              m_axi_arready_i,
    input  fw_pkg::data_t     m_axi_rdata_i,
    input  fw_pkg::axi_resp_e m_axi_rresp_i,
    input  logic              m_axi_rvalid_i,
    output logic              m_axi_rready_o,

    // ==============================
    // Control and status
    // ==============================
    input  logic              lockdown_i,
    input  logic              clear_counts_i,
    input  fw_pkg::cnt_t      timeout_cycles_i,
    input  fw_pkg::cnt_t      max_outstanding_i,
    input  fw_pkg::axi_resp_e resp_on_timeout_i,
    input  fw_pkg::data_t     rdata_on_timeout_i,
    output fw_pkg::cnt_t      timeout_count_o,
    output fw_pkg::cnt_t      unsolicited_count_o,
    output logic              evt_timeout_o,
    output logic              evt_unsolicited_o
);

    import fw_pkg::*;

    logic wr_room;
    logic rd_room;
    logic wr_issue;
    logic rd_issue;
    logic wr_timeout;
    logic rd_timeout;
    logic wr_unsol;
    logic rd_unsol;

    b_payload_t b_synth;
    b_payload_t b_dn;
    b_payload_t b_up;
    r_payload_t r_synth;
    r_payload_t r_dn;
    r_payload_t r_up;

    // Request payloads bypass the gate
    assign m_axi_awaddr_o = s_axi_awaddr_i;
    assign m_axi_wdata_o  = s_axi_wdata_i;
    assign m_axi_wstrb_o  = s_axi_wstrb_i;
    assign m_axi_araddr_o = s_axi_araddr_i;

    // Response payload packing
    assign b_synth.resp = resp_on_timeout_i;
    assign b_dn.resp    = m_axi_bresp_i;
    assign s_axi_bresp_o = b_up.resp;

    assign r_synth.data = rdata_on_timeout_i;
    assign r_synth.resp = resp_on_timeout_i;
    assign r_dn.data    = m_axi_rdata_i;
    assign r_dn.resp    = m_axi_rresp_i;
    assign s_axi_rdata_o = r_up.data;
    assign s_axi_rresp_o = r_up.resp;

    fw_request_gate u_gate (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lockdown_i  (lockdown_i),
        .wr_room_i   (wr_room),
        .rd_room_i   (rd_room),
        .s_awvalid_i (s_axi_awvalid_i),
        .s_wvalid_i  (s_axi_wvalid_i),
        .s_arvalid_i (s_axi_arvalid_i),
        .m_awready_i (m_axi_awready_i),
        .m_wready_i  (m_axi_wready_i),
        .m_arready_i (m_axi_arready_i),
        .s_awready_o (s_axi_awready_o),
        .s_wready_o  (s_axi_wready_o),
        .s_arready_o (s_axi_arready_o),
        .m_awvalid_o (m_axi_awvalid_o),
        .m_wvalid_o  (m_axi_wvalid_o),
        .m_arvalid_o (m_axi_arvalid_o),
        .wr_issue_o  (wr_issue),
        .rd_issue_o  (rd_issue)
    );

    // Write response channel
    fw_response_guard #(.payload_t(b_payload_t)) u_wr_guard (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .issue_i           (wr_issue),
        .timeout_cycles_i  (timeout_cycles_i),
        .max_outstanding_i (max_outstanding_i),
        .synth_payload_i   (b_synth),
        .dn_valid_i        (m_axi_bvalid_i),
        .dn_payload_i      (b_dn),
        .dn_ready_o        (m_axi_bready_o),
        .up_valid_o        (s_axi_bvalid_o),
        .up_payload_o      (b_up),
        .up_ready_i        (s_axi_bready_i),
        .room_o            (wr_room),
        .timeout_o         (wr_timeout),
        .unsolicited_o     (wr_unsol)
    );

    // Read response channel
    fw_response_guard #(.payload_t(r_payload_t)) u_rd_guard (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .issue_i           (rd_issue),
        .timeout_cycles_i  (timeout_cycles_i),
        .max_outstanding_i (max_outstanding_i),
        .synth_payload_i   (r_synth),
        .dn_valid_i        (m_axi_rvalid_i),
        .dn_payload_i      (r_dn),
        .dn_ready_o        (m_axi_rready_o),
        .up_valid_o        (s_axi_rvalid_o),
        .up_payload_o      (r_up),
        .up_ready_i        (s_axi_rready_i),
        .room_o            (rd_room),
        .timeout_o         (rd_timeout),
        .unsolicited_o     (rd_unsol)
    );

    fw_event_counter u_events (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .wr_timeout_i        (wr_timeout),
        .rd_timeout_i        (rd_timeout),
        .wr_unsolicited_i    (wr_unsol),
        .rd_unsolicited_i    (rd_unsol),
        .clear_counts_i      (clear_counts_i),
        .timeout_count_o     (timeout_count_o),
        .unsolicited_count_o (unsolicited_count_o),
        .evt_timeout_o       (evt_timeout_o),
        .evt_unsolicited_o   (evt_unsolicited_o)
    );

endmodule

/* bench/fw_sva.sv */
// Firewall protocol assertions, bound to the top level
// Response hold, lockdown blocking, timeout counter monotonicity

module fw_sva (
    input logic         clk_i,
    input logic         rst_ni,
    input logic         s_axi_bvalid_o,
    input logic         s_axi_bready_i,
    input logic [1:0]   s_axi_bresp_o,
    input logic         s_axi_rvalid_o,
    input logic         s_axi_rready_i,
    input fw_pkg::data_t s_axi_rdata_o,
    input logic [1:0]   s_axi_rresp_o,
    input logic         m_axi_awvalid_o,
    input logic         m_axi_wvalid_o,
    input logic         m_axi_arvalid_o,
    input logic         lockdown_i,
    input logic         clear_counts_i,
    input fw_pkg::cnt_t timeout_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Upstream responses hold until taken
    a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o))
        else $error("B response dropped or changed before accept");

    a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        s_axi_rvalid_o && !s_axi_rready_i |=>
        s_axi_rvalid_o && $stable(s_axi_rdata_o) && $stable(s_axi_rresp_o))
        else $error("R response dropped or changed before accept");

    // Nothing reaches the target while locked down
    a_lockdown: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lockdown_i |-> !(m_axi_awvalid_o || m_axi_wvalid_o || m_axi_arvalid_o))
        else $error("downstream request valid during lockdown");

    a_count_mono: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$past(clear_counts_i) |-> timeout_count_o >= $past(timeout_count_o))
        else $error("timeout counter decreased without clear");

endmodule

bind axil_firewall fw_sva u_sva (.*);

/* bench/tb_axil_firewall.sv */
// Testbench for the AXI-Lite firewall
// Clock, reset, in-order downstream responder with hold and inject
// Reference read data, upstream stimulus, response compare process

`include "fw_cfg.svh"

module tb_axil_firewall;

    timeunit 1ns;
    timeprecision 100ps;

    import fw_pkg::*;

    localparam logic [`FW_DATA_WIDTH-1:0] RD_KEY = 32'hA5C3_0F96;
    localparam int TMO = 40;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    addr_t s_axi_awaddr_i, s_axi_araddr_i, m_axi_awaddr_o, m_axi_araddr_o;
    data_t s_axi_wdata_i, s_axi_rdata_o, m_axi_wdata_o, m_axi_rdata_i, rdata_on_timeout_i;
    strb_t s_axi_wstrb_i, m_axi_wstrb_o;
    logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
    logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
    logic s_axi_rvalid_o, s_axi_rready_i;
    logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wvalid_o, m_axi_wready_i;
    logic m_axi_bvalid_i, m_axi_bready_o, m_axi_arvalid_o, m_axi_arready_i;
    logic m_axi_rvalid_i, m_axi_rready_o;
    axi_resp_e s_axi_bresp_o, s_axi_rresp_o, m_axi_bresp_i, m_axi_rresp_i, resp_on_timeout_i;
    logic lockdown_i, clear_counts_i, evt_timeout_o, evt_unsolicited_o;
    cnt_t timeout_cycles_i, max_outstanding_i, timeout_count_o, unsolicited_count_o;

    // Responder state
    addr_t rd_addr_q[$];
    int wr_pend = 0;
    int rd_wait = 0;
    int wr_wait = 0;
    int inj_cnt = 0;
    int inj_seen = 0;
    logic hold_rd = 1'b0;
    logic hold_wr = 1'b0;

    // Expected upstream responses and bookkeeping
    axi_resp_e exp_b_q[$];
    r_payload_t exp_r_q[$];
    axi_resp_e exp_b;
    r_payload_t exp_r;
    addr_t wr_addr_exp = '0;
    int cmp_errors = 0;
    int seq_errors = 0;
    int exp_to = 0;
    int exp_un = 0;
    int evt_to_n = 0;
    int evt_un_n = 0;
    int tot_to = 0;
    int tot_un = 0;

    axil_firewall dut0 (.*);

    always #2 clk_i = ~clk_i;

    // Host back-pressure on B and R, ready about three cycles in four
    always @(posedge clk_i) begin
        if (rst_ni) begin
            s_axi_bready_i <= ($urandom_range(3, 0) != 0);
            s_axi_rready_i <= ($urandom_range(3, 0) != 0);
        end
    end

    // Target memory returns address-derived data
    function automatic data_t exp_rdata(input addr_t addr);
        return addr ^ RD_KEY;
    endfunction

    // ==============================
    // Downstream responder
    // ==============================
    always @(posedge clk_i) begin
        // Write request payloads pass through unchanged
        if (m_axi_awvalid_o && m_axi_awready_i && m_axi_awaddr_o !== wr_addr_exp) begin
            cmp_errors++;
            $display("mismatch at %0t m_axi_awaddr_o got %h expected %h",
                     $time, m_axi_awaddr_o, wr_addr_exp);
        end
        if (m_axi_wvalid_o && m_axi_wready_i) begin
            if (m_axi_wdata_o !== data_t'(~wr_addr_exp)) begin
                cmp_errors++;
                $display("mismatch at %0t m_axi_wdata_o got %h expected %h",
                         $time, m_axi_wdata_o, data_t'(~wr_addr_exp));
            end
            if (m_axi_wstrb_o !== strb_t'('1)) begin
                cmp_errors++;
                $display("mismatch at %0t m_axi_wstrb_o got %h expected %h",
                         $time, m_axi_wstrb_o, strb_t'('1));
            end
        end
        if (m_axi_arvalid_o && m_axi_arready_i) rd_addr_q.push_back(m_axi_araddr_o);
        if (m_axi_rvalid_i && m_axi_rready_o) begin
            void'(rd_addr_q.pop_front());
            m_axi_rvalid_i <= 1'b0;
            rd_wait = $urandom_range(3, 0);
        end else if (!m_axi_rvalid_i && rd_addr_q.size() > 0 && !hold_rd) begin
            if (rd_wait == 0) begin
                m_axi_rvalid_i <= 1'b1;
                m_axi_rdata_i  <= exp_rdata(rd_addr_q[0]);
            end else begin
                rd_wait--;
            end
        end
        // Write responses, injected extras count as one more owed
        if (m_axi_awvalid_o && m_axi_awready_i) wr_pend++;
        if (inj_cnt != inj_seen) begin
            inj_seen++;
            wr_pend++;
        end
        if (m_axi_bvalid_i && m_axi_bready_o) begin
            wr_pend--;
            m_axi_bvalid_i <= 1'b0;
            wr_wait = $urandom_range(3, 0);
        end else if (!m_axi_bvalid_i && wr_pend > 0 && !hold_wr) begin
            if (wr_wait == 0) m_axi_bvalid_i <= 1'b1;
            else wr_wait--;
        end
    end

    // ==============================
    // Compare process
    // ==============================
    always @(posedge clk_i) begin
        if (rst_ni && s_axi_bvalid_o && s_axi_bready_i) begin
            if (exp_b_q.size() == 0) begin
                cmp_errors++;
                $display("unexpected write response reached the host at %0t", $time);
            end else begin
                exp_b = exp_b_q.pop_front();
                if (s_axi_bresp_o !== exp_b) begin
                    cmp_errors++;
                    $display("mismatch at %0t s_axi_bresp_o got %0h expected %0h",
                             $time, s_axi_bresp_o, exp_b);
                end
            end
        end
        if (rst_ni && s_axi_rvalid_o && s_axi_rready_i) begin
            if (exp_r_q.size() == 0) begin
                cmp_errors++;
                $display("unexpected read response reached the host at %0t", $time);
            end else begin
                exp_r = exp_r_q.pop_front();
                if (s_axi_rdata_o !== exp_r.data) begin
                    cmp_errors++;
                    $display("mismatch at %0t s_axi_rdata_o got %h expected %h",
                             $time, s_axi_rdata_o, exp_r.data);
                end
                if (s_axi_rresp_o !== exp_r.resp) begin
                    cmp_errors++;
                    $display("mismatch at %0t s_axi_rresp_o got %0h expected %0h",
                             $time, s_axi_rresp_o, exp_r.resp);
                end
            end
        end
        if (rst_ni && evt_timeout_o) evt_to_n++;
        if (rst_ni && evt_unsolicited_o) evt_un_n++;
    end

    // ==============================
    // Stimulus tasks
    // ==============================
    task automatic do_write(input addr_t addr, input logic synth);
        int n;
        logic aw_done;
        logic w_done;
        n = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk_i);
        wr_addr_exp = addr;
        s_axi_awaddr_i  <= addr;
        s_axi_wdata_i   <= ~addr;
        s_axi_wstrb_i   <= '1;
        s_axi_awvalid_i <= 1'b1;
        s_axi_wvalid_i  <= 1'b1;
        while (!(aw_done && w_done) && n < 200) begin
            @(posedge clk_i);
            n++;
            if (s_axi_awvalid_i && s_axi_awready_o) begin
                aw_done = 1'b1;
                s_axi_awvalid_i <= 1'b0;
            end
            if (s_axi_wvalid_i && s_axi_wready_o) begin
                w_done = 1'b1;
                s_axi_wvalid_i <= 1'b0;
            end
        end
        if (!(aw_done && w_done)) begin
            seq_errors++;
            $display("write request was never accepted at %0t", $time);
        end
        exp_b_q.push_back(synth ? resp_on_timeout_i : RESP_OKAY);
    endtask

    task automatic do_read(input addr_t addr, input logic synth);
        int n;
        r_payload_t e;
        n = 0;
        @(posedge clk_i);
        s_axi_araddr_i  <= addr;
        s_axi_arvalid_i <= 1'b1;
        do begin
            @(posedge clk_i);
            n++;
        end while (!(s_axi_arvalid_i && s_axi_arready_o) && n < 200);
        if (!s_axi_arready_o) begin
            seq_errors++;
            $display("read request was never accepted at %0t", $time);
        end
        s_axi_arvalid_i <= 1'b0;
        e.data = synth ? rdata_on_timeout_i : exp_rdata(addr);
        e.resp = synth ? resp_on_timeout_i : RESP_OKAY;
        exp_r_q.push_back(e);
    endtask

    // Synthetic response must show up within the timer window plus two
    task automatic wait_synth(input logic is_read);
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!(is_read ? s_axi_rvalid_o : s_axi_bvalid_o) && n < TMO + 2);
        if (!(is_read ? s_axi_rvalid_o : s_axi_bvalid_o)) begin
            seq_errors++;
            $display("no synthetic response within the timeout window at %0t", $time);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_b_q.size() != 0 || exp_r_q.size() != 0 || rd_addr_q.size() != 0
                || wr_pend != 0 || inj_cnt != inj_seen) && n < 300) begin
            @(posedge clk_i);
            n++;
        end
        if (n >= 300) begin
            seq_errors++;
            $display("traffic did not drain at %0t", $time);
        end
        repeat (3) @(posedge clk_i);
    endtask

    task automatic check_counts();
        if (timeout_count_o !== cnt_t'(exp_to)) begin
            seq_errors++;
            $display("mismatch at %0t timeout_count_o got %0d expected %0d",
                     $time, timeout_count_o, exp_to);
        end
        if (unsolicited_count_o !== cnt_t'(exp_un)) begin
            seq_errors++;
            $display("mismatch at %0t unsolicited_count_o got %0d expected %0d",
                     $time, unsolicited_count_o, exp_un);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        void'($urandom(98));
        {s_axi_awvalid_i, s_axi_wvalid_i, s_axi_arvalid_i} = '0;
        s_axi_awaddr_i = '0;
        s_axi_araddr_i = '0;
        s_axi_wdata_i = '0;
        s_axi_wstrb_i = '0;
        s_axi_bready_i = 1'b1;
        s_axi_rready_i = 1'b1;
        {m_axi_awready_i, m_axi_wready_i, m_axi_arready_i} = '1;
        {m_axi_bvalid_i, m_axi_rvalid_i} = '0;
        m_axi_bresp_i = RESP_OKAY;
        m_axi_rresp_i = RESP_OKAY;
        m_axi_rdata_i = '0;
        lockdown_i = 1'b0;
        clear_counts_i = 1'b0;
        timeout_cycles_i = TMO;
        max_outstanding_i = 16;
        resp_on_timeout_i = RESP_SLVERR;
        rdata_on_timeout_i = 32'hDEAD_BEEF;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Normal traffic
        repeat (8) begin
            do_write($urandom, 1'b0);
            do_read($urandom, 1'b0);
        end
        wait_idle();
        check_counts();

        // Read and write timeouts, late responses swallowed afterwards
        hold_rd <= 1'b1;
        do_read($urandom, 1'b1);
        wait_synth(1'b1);
        hold_rd <= 1'b0;
        exp_to++;
        exp_un++;
        wait_idle();
        check_counts();
        hold_wr <= 1'b1;
        do_write($urandom, 1'b1);
        wait_synth(1'b0);
        hold_wr <= 1'b0;
        exp_to++;
        exp_un++;
        wait_idle();
        check_counts();

        // Extra response with nothing outstanding
        inj_cnt++;
        exp_un++;
        wait_idle();
        check_counts();

        // Outstanding limit of two with a stalled target
        max_outstanding_i <= 2;
        hold_rd <= 1'b1;
        do_read($urandom, 1'b0);
        do_read($urandom, 1'b0);
        fork
            do_read($urandom, 1'b0);
            begin
                repeat (3) @(posedge clk_i);
                if (m_axi_arvalid_o || s_axi_arready_o) begin
                    seq_errors++;
                    $display("third read passed the outstanding limit at %0t", $time);
                end
                hold_rd <= 1'b0;
            end
        join
        wait_idle();
        max_outstanding_i <= 16;

        // Lockdown holds a read back until released
        lockdown_i <= 1'b1;
        fork
            do_read($urandom, 1'b0);
            begin
                repeat (8) begin
                    @(posedge clk_i);
                    if (m_axi_arvalid_o) begin
                        seq_errors++;
                        $display("read reached the target during lockdown at %0t", $time);
                    end
                end
                lockdown_i <= 1'b0;
            end
        join
        wait_idle();
        check_counts();

        // Clear both counters
        tot_to = exp_to;
        tot_un = exp_un;
        @(posedge clk_i);
        clear_counts_i <= 1'b1;
        @(posedge clk_i);
        clear_counts_i <= 1'b0;
        @(posedge clk_i);
        exp_to = 0;
        exp_un = 0;
        check_counts();

        if (evt_to_n != tot_to || evt_un_n != tot_un) begin
            seq_errors++;
            $display("event pulse count wrong, timeout %0d of %0d, unsolicited %0d of %0d",
                     evt_to_n, tot_to, evt_un_n, tot_un);
        end

        $display("compare errors %0d, sequence errors %0d", cmp_errors, seq_errors);
        if (cmp_errors == 0 && seq_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
logic/fw_pkg.sv
logic/fw_request_gate.sv
logic/fw_response_guard.sv
logic/fw_event_counter.sv
logic/axil_firewall.sv
bench/fw_sva.sv
bench/tb_axil_firewall.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AXI-Lite firewall testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f build.f \
    --top-module tb_axil_firewall \
    -Mdir obj_dir

./obj_dir/Vtb_axil_firewall 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
